/* logic/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define NUM_ICACHE_LINES 32
`define LINE_OFS_BITS    3                      // byte offset inside a 64-bit line
`define ICACHE_IDX_BITS  ($clog2(`NUM_ICACHE_LINES))

// memory bus tags, tag 0 means none
`define NUM_MEM_TAGS     16
`define MEM_TAG_BITS     ($clog2(`NUM_MEM_TAGS))

// fetch address space covered by the cache tags
`define FETCH_ADDR_BITS  16
`define ICACHE_TAG_BITS  (`FETCH_ADDR_BITS - `ICACHE_IDX_BITS - `LINE_OFS_BITS)

// cycles from acceptance to returned data
`define MEM_LATENCY      6

`endif

/* logic/icache_pkg.sv */
`default_nettype none
`include "icache_cfg.svh"

package icache_pkg;

  // ------------------------------------------------------------
  // memory bus
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } mem_cmd_t;

  typedef struct packed {
    mem_cmd_t    cmd;
    logic [63:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_TAG_BITS-1:0] rsp_tag;                // same cycle, 0 = refused
    logic [`MEM_TAG_BITS-1:0] data_tag;               // tag of the data below
    logic [63:0]              data;
  } mem_rsp_t;

  // ------------------------------------------------------------
  // cache storage
  // ------------------------------------------------------------
  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_TAG_BITS-1:0] tag;
    logic [63:0]                 data;
  } icache_line_t;

  typedef struct packed {
    logic [`ICACHE_IDX_BITS-1:0] idx;
    logic [`ICACHE_TAG_BITS-1:0] tag;
  } mem_tag_entry_t;

  // ------------------------------------------------------------
  // fetch and config ports
  // ------------------------------------------------------------
  typedef enum logic [1:0] {IDLE, WAIT_HIT, ACK_HI} fetch_state_t;

  typedef enum logic [1:0] {
    CFG_SET_PREFETCH,
    CFG_FLUSH,
    CFG_READ_HITS,
    CFG_READ_MISSES
  } cfg_op_t;

  typedef struct packed {
    cfg_op_t     op;
    logic [31:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [31:0] hits;
    logic [31:0] misses;
  } icache_stats_t;

endpackage

`default_nettype wire

/* logic/icache.sv */
`default_nettype none
`include "icache_cfg.svh"

module icache import icache_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [`FETCH_ADDR_BITS-1:0] i_lookup_addr,
  input  logic                        i_prefetch_en,
  input  logic                        i_flush,
  input  mem_rsp_t                    i_mem_rsp,
  output mem_req_t                    o_mem_req,
  output logic [63:0]                 o_data,
  output logic                        o_valid
);

  icache_line_t             lines     [`NUM_ICACHE_LINES];
  mem_tag_entry_t           tag_table [`NUM_MEM_TAGS];   // one entry per memory tag
  logic [`NUM_MEM_TAGS-1:0] tag_live;                    // outstanding tags

  logic [`ICACHE_IDX_BITS-1:0] idx;
  logic [`ICACHE_IDX_BITS-1:0] head;
  logic [`ICACHE_IDX_BITS-1:0] tail;
  logic [`ICACHE_IDX_BITS-1:0] tail_inc;
  logic [`ICACHE_IDX_BITS-1:0] idx_off;
  logic [`ICACHE_IDX_BITS-1:0] tail_off;
  logic [`ICACHE_IDX_BITS-1:0] req_idx;
  logic [`ICACHE_TAG_BITS-1:0] tag;
  logic [`ICACHE_TAG_BITS-1:0] head_tag;
  logic [`ICACHE_TAG_BITS-1:0] pf_tag;
  logic [`ICACHE_TAG_BITS-1:0] req_tag;
  logic                        in_win;
  logic                        match;
  logic                        hit_win;
  logic                        use_pf;
  logic                        accepted;
  logic                        data_back;
  logic                        fill_ok;
  mem_tag_entry_t              fill_entry;
  mem_cmd_t                    cmd_q;

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------
  assign idx   = i_lookup_addr[`LINE_OFS_BITS +: `ICACHE_IDX_BITS];
  assign tag   = i_lookup_addr[`FETCH_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  assign match = lines[idx].tag == tag;

  assign o_data  = lines[idx].data;
  assign o_valid = lines[idx].valid && match;

  // window is [head, tail), modulo the line count
  assign idx_off  = idx - head;
  assign tail_off = tail - head;
  assign in_win   = idx_off < tail_off;
  assign hit_win  = in_win && match;
  assign use_pf   = hit_win && i_prefetch_en;
  assign tail_inc = tail + 1'b1;
  assign pf_tag   = (tail < head) ? head_tag + 1'b1 : head_tag;   // stream wrapped past 0

  // ------------------------------------------------------------
  // memory request
  // ------------------------------------------------------------
  assign req_idx  = use_pf ? tail : idx;
  assign req_tag  = use_pf ? pf_tag : tag;
  assign accepted = (i_mem_rsp.rsp_tag != '0) && (cmd_q == BUS_LOAD);

  always_comb begin
    o_mem_req.cmd  = cmd_q;
    o_mem_req.addr = 64'({req_tag, req_idx, {`LINE_OFS_BITS{1'b0}}});
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q <= BUS_NONE;
    end else begin
      cmd_q <= BUS_LOAD;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || i_flush) begin
      head     <= '0;
      tail     <= '0;
      head_tag <= '0;
    end else if (accepted && !hit_win) begin   // demand restarts the stream
      head     <= idx;
      tail     <= idx + 1'b1;
      head_tag <= tag;
    end else if (accepted && use_pf && (tail_inc != head)) begin
      tail <= tail_inc;
    end
  end

  // ------------------------------------------------------------
  // tag table and fills
  // ------------------------------------------------------------
  assign data_back  = i_mem_rsp.data_tag != '0;
  assign fill_entry = tag_table[i_mem_rsp.data_tag];
  assign fill_ok    = data_back && tag_live[i_mem_rsp.data_tag] &&
                      (fill_entry.tag == lines[fill_entry.idx].tag);

  always_ff @(posedge clock) begin
    if (accepted) begin
      tag_table[i_mem_rsp.rsp_tag] <= '{idx: req_idx, tag: req_tag};
    end
  end

  always_ff @(posedge clock) begin
    if (reset || i_flush) begin
      tag_live <= '0;                          // drop fills still in flight
    end else begin
      if (data_back) begin
        tag_live[i_mem_rsp.data_tag] <= 1'b0;
      end
      if (accepted) begin
        tag_live[i_mem_rsp.rsp_tag] <= 1'b1;   // reuse in the same cycle wins
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_ok) begin
      lines[fill_entry.idx].data  <= i_mem_rsp.data;
      lines[fill_entry.idx].valid <= 1'b1;
    end
    if (accepted && (lines[req_idx].tag != req_tag)) begin
      lines[req_idx].tag   <= req_tag;         // new owner, old data is stale
      lines[req_idx].valid <= 1'b0;
    end
    if (reset || i_flush) begin
      for (int i = 0; i < `NUM_ICACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/icache_ctrl_regs.sv */
`default_nettype none

module icache_ctrl_regs import icache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        i_cfg_req,
  input  cfg_req_t    i_cfg,
  input  logic        i_hit,
  input  logic        i_miss,
  output logic        o_cfg_ack,
  output logic [31:0] o_cfg_rdata,
  output logic        o_prefetch_en,
  output logic        o_flush
);

  logic          pending;                      // req sampled, op runs next cycle
  logic          do_flush;
  icache_stats_t stats;

  assign do_flush = pending && (i_cfg.op == CFG_FLUSH);

  // ------------------------------------------------------------
  // four-phase handshake and control bits
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pending       <= 1'b0;
      o_cfg_ack     <= 1'b0;
      o_prefetch_en <= 1'b1;
      o_flush       <= 1'b0;
    end else begin
      o_flush <= 1'b0;
      if (pending) begin
        pending   <= 1'b0;
        o_cfg_ack <= 1'b1;
        if (i_cfg.op == CFG_SET_PREFETCH) begin
          o_prefetch_en <= i_cfg.wdata[0];
        end
        o_flush <= do_flush;                   // cache sees it while ack is high
      end else if (i_cfg_req && !o_cfg_ack) begin
        pending <= 1'b1;
      end else if (o_cfg_ack && !i_cfg_req) begin
        o_cfg_ack <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // hit and miss counters
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || do_flush) begin
      stats <= '0;
    end else begin
      if (i_hit) begin
        stats.hits <= stats.hits + 32'd1;
      end
      if (i_miss) begin
        stats.misses <= stats.misses + 32'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pending) begin
      case (i_cfg.op)
        CFG_READ_HITS:   o_cfg_rdata <= stats.hits;
        CFG_READ_MISSES: o_cfg_rdata <= stats.misses;
        default:         o_cfg_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`default_nettype none
`include "icache_cfg.svh"

module fetch_unit import icache_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        i_fetch_req,
  input  logic [`FETCH_ADDR_BITS-1:0] i_fetch_addr,
  input  logic [63:0]                 i_cache_data,
  input  logic                        i_cache_valid,
  output logic                        o_fetch_ack,
  output logic [63:0]                 o_fetch_data,
  output logic [`FETCH_ADDR_BITS-1:0] o_lookup_addr,
  output logic                        o_hit,
  output logic                        o_miss
);

  fetch_state_t                state;
  logic                        first;          // first lookup cycle of a request
  logic [`FETCH_ADDR_BITS-1:0] addr_q;
  logic [63:0]                 data_q;

  assign o_lookup_addr = addr_q;
  assign o_fetch_ack   = state == ACK_HI;
  assign o_fetch_data  = data_q;

  // classify once per request
  assign o_hit  = (state == WAIT_HIT) && first && i_cache_valid;
  assign o_miss = (state == WAIT_HIT) && first && !i_cache_valid;

  // ------------------------------------------------------------
  // request FSM
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= IDLE;
      first  <= 1'b0;
      addr_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_fetch_req) begin
            addr_q <= i_fetch_addr;
            first  <= 1'b1;
            state  <= WAIT_HIT;
          end
        end
        WAIT_HIT: begin
          first <= 1'b0;
          if (i_cache_valid) begin
            state <= ACK_HI;
          end
        end
        ACK_HI: begin
          if (!i_fetch_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == WAIT_HIT) && i_cache_valid) begin
      data_q <= i_cache_data;
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none
`include "icache_cfg.svh"

module fetch_top import icache_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        i_fetch_req,
  input  logic [`FETCH_ADDR_BITS-1:0] i_fetch_addr,
  input  logic                        i_cfg_req,
  input  cfg_req_t                    i_cfg,
  input  mem_rsp_t                    i_mem_rsp,
  output logic                        o_fetch_ack,
  output logic [63:0]                 o_fetch_data,
  output logic                        o_cfg_ack,
  output logic [31:0]                 o_cfg_rdata,
  output mem_req_t                    o_mem_req
);

  logic [`FETCH_ADDR_BITS-1:0] lookup_addr;
  logic [63:0]                 cache_data;
  logic                        cache_valid;
  logic                        hit;
  logic                        miss;
  logic                        prefetch_en;
  logic                        flush;

  fetch_unit fetch_unit_inst (
    .clock         (clock),
    .reset         (reset),
    .i_fetch_req   (i_fetch_req),
    .i_fetch_addr  (i_fetch_addr),
    .i_cache_data  (cache_data),
    .i_cache_valid (cache_valid),
    .o_fetch_ack   (o_fetch_ack),
    .o_fetch_data  (o_fetch_data),
    .o_lookup_addr (lookup_addr),
    .o_hit         (hit),
    .o_miss        (miss)
  );

  icache icache_inst (
    .clock         (clock),
    .reset         (reset),
    .i_lookup_addr (lookup_addr),
    .i_prefetch_en (prefetch_en),
    .i_flush       (flush),
    .i_mem_rsp     (i_mem_rsp),
    .o_mem_req     (o_mem_req),
    .o_data        (cache_data),
    .o_valid       (cache_valid)
  );

  icache_ctrl_regs icache_ctrl_regs_inst (
    .clock         (clock),
    .reset         (reset),
    .i_cfg_req     (i_cfg_req),
    .i_cfg         (i_cfg),
    .i_hit         (hit),
    .i_miss        (miss),
    .o_cfg_ack     (o_cfg_ack),
    .o_cfg_rdata   (o_cfg_rdata),
    .o_prefetch_en (prefetch_en),
    .o_flush       (flush)
  );

endmodule

`default_nettype wire

/* tb/mem_model.sv */
`default_nettype none
`include "icache_cfg.svh"

module mem_model import icache_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t i_mem_req,
  output mem_rsp_t o_mem_rsp
);

  typedef struct packed {
    logic [`MEM_TAG_BITS-1:0] tag;
    logic [63:0]              addr;
  } inflight_t;

  inflight_t                pipe [`MEM_LATENCY];
  logic [`MEM_TAG_BITS-1:0] next_tag;
  logic                     refuse;               // refusal drawn for this cycle
  integer                   seed = 67;

  // tag answers in the same cycle, data leaves the end of the pipe
  always_comb begin
    o_mem_rsp.rsp_tag  = ((i_mem_req.cmd == BUS_LOAD) && !refuse) ? next_tag : '0;
    o_mem_rsp.data_tag = pipe[`MEM_LATENCY-1].tag;
    o_mem_rsp.data     = {pipe[`MEM_LATENCY-1].addr[31:0], ~pipe[`MEM_LATENCY-1].addr[31:0]};
  end

  always @(posedge clock) begin
    if (reset) begin
      next_tag <= 1;
      refuse   <= 1'b0;
      for (int i = 0; i < `MEM_LATENCY; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      refuse  <= ($random(seed) & 3) == 0;     // about one cycle in four
      pipe[0] <= '{tag: o_mem_rsp.rsp_tag, addr: i_mem_req.addr};
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
      if (o_mem_rsp.rsp_tag != '0) begin
        next_tag <= (&next_tag) ? 1 : next_tag + 1'b1;   // round robin, 0 skipped
      end
    end
  end

endmodule

`default_nettype wire

/* tb/fetch_props.sv */
`default_nettype none

module fetch_props import icache_pkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     i_fetch_req,
  input logic     o_fetch_ack,
  input mem_req_t o_mem_req
);

  int unsigned assert_fails = 0;

  ack_needs_req: assert property (@(posedge clock) disable iff (reset)
      $rose(o_fetch_ack) |-> i_fetch_req)
    else begin
      assert_fails++;
      $error("fetch ack rose while req was low");
    end

  req_held: assert property (@(posedge clock) disable iff (reset)
      i_fetch_req && !o_fetch_ack |=> i_fetch_req)
    else begin
      assert_fails++;
      $error("fetch req dropped before ack");
    end

  // command register leaves BUS_NONE one cycle after reset
  cmd_load: assert property (@(posedge clock)
      !reset && $past(!reset) |-> o_mem_req.cmd == BUS_LOAD)
    else begin
      assert_fails++;
      $error("memory command is not BUS_LOAD outside reset");
    end

endmodule

bind fetch_top fetch_props fetch_props_inst (
  .clock       (clock),
  .reset       (reset),
  .i_fetch_req (i_fetch_req),
  .o_fetch_ack (o_fetch_ack),
  .o_mem_req   (o_mem_req)
);

`default_nettype wire

/* tb/fetch_tb.sv */
`default_nettype none
`include "icache_cfg.svh"

module fetch_tb import icache_pkg::*; ();

  localparam int NUM_TESTS       = 6;
  localparam int MAX_ACCESSES    = 24;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_ACCESSES * (`MEM_LATENCY + 20);

  localparam logic [`FETCH_ADDR_BITS-1:0] ADDR_A   = 16'h1000;
  localparam logic [`FETCH_ADDR_BITS-1:0] ADDR_B   = 16'h2008;   // next index after ADDR_A
  localparam logic [`FETCH_ADDR_BITS-1:0] ADDR_SEQ = 16'h3000;
  localparam logic [`FETCH_ADDR_BITS-1:0] ADDR_X   = 16'h5010;
  localparam logic [`FETCH_ADDR_BITS-1:0] ADDR_Y   = 16'h5110;   // same index, other tag

  logic                        clock;
  logic                        reset;
  logic                        fetch_req;
  logic [`FETCH_ADDR_BITS-1:0] fetch_addr;
  logic                        fetch_ack;
  logic [63:0]                 fetch_data;
  logic                        cfg_req;
  cfg_req_t                    cfg;
  logic                        cfg_ack;
  logic [31:0]                 cfg_rdata;
  mem_req_t                    mem_req;
  mem_rsp_t                    mem_rsp;

  integer      seed = 67;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned tests_done = 0;
  logic        ack_seen = 1'b0;

  fetch_top fetch_top_inst (
    .clock        (clock),
    .reset        (reset),
    .i_fetch_req  (fetch_req),
    .i_fetch_addr (fetch_addr),
    .i_cfg_req    (cfg_req),
    .i_cfg        (cfg),
    .i_mem_rsp    (mem_rsp),
    .o_fetch_ack  (fetch_ack),
    .o_fetch_data (fetch_data),
    .o_cfg_ack    (cfg_ack),
    .o_cfg_rdata  (cfg_rdata),
    .o_mem_req    (mem_req)
  );

  mem_model mem_model_inst (
    .clock     (clock),
    .reset     (reset),
    .i_mem_req (mem_req),
    .o_mem_rsp (mem_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // line address followed by its inverse
  function automatic logic [63:0] mem_word(input logic [`FETCH_ADDR_BITS-1:0] addr);
    logic [31:0] line_addr;
    line_addr = 32'(addr >> `LINE_OFS_BITS) << `LINE_OFS_BITS;
    return {line_addr, ~line_addr};
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // each rising ack is compared with the reference
  always @(negedge clock) begin
    if (fetch_ack && !ack_seen) begin
      check_data("o_fetch_data", fetch_data, mem_word(fetch_addr));
    end
    ack_seen = fetch_ack;
  end

  // ------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------
  task automatic run_fetch(input logic [`FETCH_ADDR_BITS-1:0] addr);
    @(posedge clock);
    fetch_req  <= 1'b1;
    fetch_addr <= addr;
    do @(negedge clock); while (!fetch_ack);
    @(posedge clock);
    fetch_req <= 1'b0;
    do @(negedge clock); while (fetch_ack);
  endtask

  task automatic cfg_access(input cfg_op_t op, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(posedge clock);
    cfg_req <= 1'b1;
    cfg     <= '{op: op, wdata: wdata};
    do @(negedge clock); while (!cfg_ack);
    rdata = cfg_rdata;
    @(posedge clock);
    cfg_req <= 1'b0;
    do @(negedge clock); while (cfg_ack);
  endtask

  task automatic expect_counts(input logic [31:0] hits, input logic [31:0] misses);
    logic [31:0] rdata;
    cfg_access(CFG_READ_HITS, 32'd0, rdata);
    check_count("hits", rdata, hits);
    cfg_access(CFG_READ_MISSES, 32'd0, rdata);
    check_count("misses", rdata, misses);
  endtask

  task automatic end_test(input string name, input int unsigned errors_before);
    tests_done++;
    $display("test %0d %s: %0d errors", tests_done, name, errors - errors_before);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] rnd;
    int unsigned err0;
    int unsigned total;
    reset      = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    cfg_req    = 1'b0;
    cfg        = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    err0 = errors;
    @(negedge clock);
    check_bit("o_fetch_ack", fetch_ack, 1'b0);
    check_bit("o_cfg_ack", cfg_ack, 1'b0);
    expect_counts(32'd0, 32'd0);
    end_test("reset state", err0);

    err0 = errors;
    repeat (20) begin
      rnd = $random(seed);
      run_fetch({1'b1, rnd[14:0]});                 // upper half keeps clear of later tests
    end
    end_test("random fetches", err0);

    err0 = errors;
    cfg_access(CFG_SET_PREFETCH, 32'd0, rdata);
    cfg_access(CFG_FLUSH, 32'd0, rdata);
    run_fetch(ADDR_A);
    run_fetch(ADDR_B);
    run_fetch(ADDR_A);
    run_fetch(ADDR_B);
    expect_counts(32'd2, 32'd2);
    end_test("hit and miss counts", err0);

    err0 = errors;
    cfg_access(CFG_FLUSH, 32'd0, rdata);
    expect_counts(32'd0, 32'd0);
    run_fetch(ADDR_A);
    expect_counts(32'd0, 32'd1);
    end_test("flush and refetch", err0);

    err0 = errors;
    cfg_access(CFG_SET_PREFETCH, 32'd1, rdata);
    cfg_access(CFG_FLUSH, 32'd0, rdata);
    for (int i = 0; i < 16; i++) begin
      run_fetch(ADDR_SEQ + (16'(i) << `LINE_OFS_BITS));
    end
    cfg_access(CFG_READ_HITS, 32'd0, rdata);
    if (rdata == 32'd0) begin
      errors++;
      $display("no prefetched line hit during the sequential run");
    end
    end_test("sequential prefetch", err0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      run_fetch(ADDR_X);
      run_fetch(ADDR_Y);
    end
    end_test("same index conflict", err0);

    total = errors + fetch_top_inst.fetch_props_inst.assert_fails;
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, total);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache.sv
logic/icache_ctrl_regs.sv
logic/fetch_unit.sv
logic/fetch_top.sv
tb/mem_model.sv
tb/fetch_props.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fetch_tb -f sim.f -Mdir obj_dir &&
./obj_dir/Vfetch_tb | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
